/* design/stap_fsm.sv */
/*
 * sTAP controller FSM
 * 16-state IEEE 1149.1 TAP controller walked by TMS on ftap_tck,
 * decoded into one strobe per active capture/shift/update state
 */

`timescale 1ns/1ps

module stap_fsm (
    input  logic                ftap_tck,
    input  logic                arst_n,
    input  logic                tms,
    output stap_pkg::tap_ctrl_t ctrl
);

    import stap_pkg::*;

    tap_state_e state;
    tap_state_e state_nxt;

    // --------------------------------------------------
    // State register
    // --------------------------------------------------
    always_ff @(posedge ftap_tck or negedge arst_n) begin
        if (!arst_n) begin
            state <= test_logic_reset;
        end else begin
            state <= state_nxt;
        end
    end

    // --------------------------------------------------
    // Next-state table
    // --------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            test_logic_reset: state_nxt = tms ? test_logic_reset : run_test_idle;
            run_test_idle:    state_nxt = tms ? select_dr_scan   : run_test_idle;
            // DR column
            select_dr_scan:   state_nxt = tms ? select_ir_scan   : capture_dr;
            capture_dr:       state_nxt = tms ? exit1_dr         : shift_dr;
            shift_dr:         state_nxt = tms ? exit1_dr         : shift_dr;
            exit1_dr:         state_nxt = tms ? update_dr        : pause_dr;
            pause_dr:         state_nxt = tms ? exit2_dr         : pause_dr;
            exit2_dr:         state_nxt = tms ? update_dr        : shift_dr;
            update_dr:        state_nxt = tms ? select_dr_scan   : run_test_idle;
            // IR column
            select_ir_scan:   state_nxt = tms ? test_logic_reset : capture_ir;
            capture_ir:       state_nxt = tms ? exit1_ir         : shift_ir;
            shift_ir:         state_nxt = tms ? exit1_ir         : shift_ir;
            exit1_ir:         state_nxt = tms ? update_ir        : pause_ir;
            pause_ir:         state_nxt = tms ? exit2_ir         : pause_ir;
            exit2_ir:         state_nxt = tms ? update_ir        : shift_ir;
            update_ir:        state_nxt = tms ? select_dr_scan   : run_test_idle;
            default:          state_nxt = test_logic_reset;
        endcase
    end

    // --------------------------------------------------
    // Control strobes
    // --------------------------------------------------
    // Pure decode of the current state
    always_comb begin
        ctrl = '0;
        case (state)
            test_logic_reset: ctrl.tlr        = 1'b1;
            capture_dr:       ctrl.capture_dr = 1'b1;
            shift_dr:         ctrl.shift_dr   = 1'b1;
            update_dr:        ctrl.update_dr  = 1'b1;
            capture_ir:       ctrl.capture_ir = 1'b1;
            shift_ir:         ctrl.shift_ir   = 1'b1;
            update_ir:        ctrl.update_ir  = 1'b1;
            // Idle, select, exit and pause states drive nothing
            default:          ctrl = '0;
        endcase
    end

endmodule

/* design/stap_ir.sv */
/*
 * sTAP instruction register
 * Capture/shift stage and update stage of the 4-bit IR, with the
 * opcode decode into the DR path select and the TDR selects
 */

`timescale 1ns/1ps

module stap_ir (
    input  logic                   ftap_tck,
    input  logic                   arst_n,
    input  logic                   tdi,
    input  stap_pkg::tap_ctrl_t    ctrl,
    output logic                   ir_so,
    output stap_tdr_pkg::tdr_sel_t tdr_sel,
    output stap_tdr_pkg::dr_path_e path
);

    import stap_pkg::*;
    import stap_tdr_pkg::*;

    ir_t ir_shift;
    ir_t ir_upd;

    // --------------------------------------------------
    // Shift stage
    // --------------------------------------------------
    // Loads the fixed capture pattern, then shifts LSB first
    always_ff @(posedge ftap_tck) begin
        if (ctrl.capture_ir) begin
            ir_shift <= IR_CAPTURE;
        end else if (ctrl.shift_ir) begin
            ir_shift <= {tdi, ir_shift[IR_WIDTH-1:1]};
        end
    end

    assign ir_so = ir_shift[0];

    // --------------------------------------------------
    // Update stage
    // --------------------------------------------------
    // Takes the new opcode on the edge leaving Update-IR
    always_ff @(posedge ftap_tck or negedge arst_n) begin
        if (!arst_n) begin
            ir_upd <= OPC_IDCODE;
        end else if (ctrl.tlr) begin
            ir_upd <= OPC_IDCODE;
        end else if (ctrl.update_ir) begin
            ir_upd <= ir_shift;
        end
    end

    // --------------------------------------------------
    // Opcode decode
    // --------------------------------------------------
    always_comb begin
        tdr_sel = '0;
        path    = path_bypass;
        case (ir_upd)
            OPC_IDCODE: path = path_idcode;
            OPC_BYPASS: path = path_bypass;
            default: begin
                // TDR window starts at OPC_TDR_BASE
                for (int k = 0; k < NUM_TDR; k++) begin
                    if (ir_upd == ir_t'(OPC_TDR_BASE + k)) begin
                        tdr_sel[k] = 1'b1;
                        path       = path_tdr;
                    end
                end
                // Anything left over falls back to bypass
            end
        endcase
    end

endmodule

/* design/stap_pkg.sv */
/*
 * sTAP protocol definitions
 * TAP controller states, instruction register opcodes and the
 * control strobes that the state machine hands to the registers
 */

package stap_pkg;

    // --------------------------------------------------
    // Instruction register
    // --------------------------------------------------
    localparam int IR_WIDTH = 4;

    typedef logic [IR_WIDTH-1:0] ir_t;

    // Opcodes
    localparam ir_t OPC_IDCODE   = 4'h1;
    // TDR k sits at OPC_TDR_BASE + k
    localparam ir_t OPC_TDR_BASE = 4'h8;
    localparam ir_t OPC_BYPASS   = 4'hF;

    // Fixed pattern loaded at Capture-IR, LSBs 01 per 1149.1
    localparam ir_t IR_CAPTURE   = 4'b0001;

    // --------------------------------------------------
    // TAP controller
    // --------------------------------------------------
    typedef enum logic [3:0] {
        test_logic_reset,
        run_test_idle,
        select_dr_scan,
        capture_dr,
        shift_dr,
        exit1_dr,
        pause_dr,
        exit2_dr,
        update_dr,
        select_ir_scan,
        capture_ir,
        shift_ir,
        exit1_ir,
        pause_ir,
        exit2_ir,
        update_ir
    } tap_state_e;

    // Decoded state strobes, at most one high at a time
    typedef struct packed {
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
        logic capture_ir;
        logic shift_ir;
        logic update_ir;
        logic tlr;
    } tap_ctrl_t;

endpackage

/* design/stap_tdo_path.sv */
/*
 * sTAP TDO path
 * Bypass and IDCODE registers, scan output mux and the
 * falling-edge retiming of TDO and its enable
 */

`timescale 1ns/1ps

module stap_tdo_path (
    input  logic                   ftap_tck,
    input  logic                   arst_n,
    input  logic                   tdi,
    input  stap_pkg::tap_ctrl_t    ctrl,
    input  stap_tdr_pkg::dr_path_e path,
    input  stap_tdr_pkg::tdr_sel_t tdr_sel,
    input  logic                   ir_so,
    input  stap_tdr_pkg::tdr_sel_t tdr_so,
    output logic                   tdo,
    output logic                   tdo_en
);

    import stap_tdr_pkg::*;

    logic    bypass_q;
    idcode_t idcode_q;
    logic    dr_bit;
    logic    scan_bit;
    logic    shift_active;

    // --------------------------------------------------
    // Bypass and IDCODE registers
    // --------------------------------------------------
    always_ff @(posedge ftap_tck) begin
        if (path == path_bypass) begin
            // Bypass captures 0 so the host sees a leading zero
            if (ctrl.capture_dr) begin
                bypass_q <= 1'b0;
            end else if (ctrl.shift_dr) begin
                bypass_q <= tdi;
            end
        end
    end

    always_ff @(posedge ftap_tck) begin
        if (path == path_idcode) begin
            if (ctrl.capture_dr) begin
                idcode_q <= IDCODE_VALUE;
            end else if (ctrl.shift_dr) begin
                idcode_q <= {tdi, idcode_q[IDCODE_WIDTH-1:1]};
            end
        end
    end

    // --------------------------------------------------
    // Output mux
    // --------------------------------------------------
    always_comb begin
        case (path)
            path_idcode: dr_bit = idcode_q[0];
            // Only the selected TDR contributes
            path_tdr:    dr_bit = |(tdr_so & tdr_sel);
            default:     dr_bit = bypass_q;
        endcase
    end

    assign shift_active = ctrl.shift_dr | ctrl.shift_ir;
    assign scan_bit     = ctrl.shift_ir ? ir_so : dr_bit;

    // Falling-edge retiming, TDO parked low outside shift states
    always_ff @(negedge ftap_tck or negedge arst_n) begin
        if (!arst_n) begin
            tdo    <= 1'b0;
            tdo_en <= 1'b0;
        end else begin
            tdo    <= shift_active ? scan_bit : 1'b0;
            tdo_en <= shift_active;
        end
    end

endmodule

/* design/stap_tdr.sv */
/*
 * sTAP test data register
 * One 8-bit TDR with parallel capture, serial shift and a
 * parallel update register that drives the block output
 */

`timescale 1ns/1ps

module stap_tdr (
    input  logic                    ftap_tck,
    input  logic                    arst_n,
    input  logic                    tdi,
    input  stap_pkg::tap_ctrl_t     ctrl,
    input  logic                    sel,
    input  stap_tdr_pkg::tdr_data_t data_in,
    output logic                    so,
    output stap_tdr_pkg::tdr_data_t data_out
);

    import stap_tdr_pkg::*;

    tdr_data_t shift_q;

    // --------------------------------------------------
    // Capture and shift stage
    // --------------------------------------------------
    // Holds its contents while another register is selected
    always_ff @(posedge ftap_tck) begin
        if (sel) begin
            if (ctrl.capture_dr) begin
                shift_q <= data_in;
            end else if (ctrl.shift_dr) begin
                // TDI enters at the MSB, LSB leaves first
                shift_q <= {tdi, shift_q[TDR_WIDTH-1:1]};
            end
        end
    end

    assign so = shift_q[0];

    // --------------------------------------------------
    // Update stage
    // --------------------------------------------------
    // Visible one cycle after Update-DR is entered
    always_ff @(posedge ftap_tck or negedge arst_n) begin
        if (!arst_n) begin
            data_out <= '0;
        end else if (ctrl.tlr) begin
            data_out <= '0;
        end else if (ctrl.update_dr && sel) begin
            data_out <= shift_q;
        end
    end

endmodule

/* design/stap_tdr_pkg.sv */
/*
 * sTAP data register definitions
 * Test data register bank size, IDCODE value and the
 * selects used to steer the DR scan path
 */

package stap_tdr_pkg;

    // --------------------------------------------------
    // Test data register bank
    // --------------------------------------------------
    localparam int NUM_TDR   = 4;
    localparam int TDR_WIDTH = 8;

    typedef logic [TDR_WIDTH-1:0] tdr_data_t;

    // One-hot select, all zero when no TDR is addressed
    typedef logic [NUM_TDR-1:0] tdr_sel_t;

    // --------------------------------------------------
    // IDCODE
    // --------------------------------------------------
    localparam int IDCODE_WIDTH = 32;

    typedef logic [IDCODE_WIDTH-1:0] idcode_t;

    // Bit 0 is tied high as the standard requires
    localparam idcode_t IDCODE_VALUE = 32'h1A5C_0F1B;

    // Register that sits between TDI and TDO during a DR scan
    typedef enum logic [1:0] {
        path_bypass,
        path_idcode,
        path_tdr
    } dr_path_e;

endpackage

/* design/stap_top.sv */
/*
 * sTAP top level
 * TAP controller, instruction register, TDR bank and
 * TDO path wired into one test access port
 */

`timescale 1ns/1ps

module stap_top (
    input  logic                                                ftap_tck,
    input  logic                                                arst_n,
    input  logic                                                tms,
    input  logic                                                tdi,
    output logic                                                tdo,
    output logic                                                tdo_en,
    input  stap_tdr_pkg::tdr_data_t [stap_tdr_pkg::NUM_TDR-1:0] tdr_data_in,
    output stap_tdr_pkg::tdr_data_t [stap_tdr_pkg::NUM_TDR-1:0] tdr_data_out
);

    import stap_pkg::*;
    import stap_tdr_pkg::*;

    tap_ctrl_t ctrl;
    tdr_sel_t  tdr_sel;
    tdr_sel_t  tdr_so;
    dr_path_e  path;
    logic      ir_so;

    // --------------------------------------------------
    // Controller and instruction register
    // --------------------------------------------------
    stap_fsm u_fsm (
        .ftap_tck (ftap_tck),
        .arst_n   (arst_n),
        .tms      (tms),
        .ctrl     (ctrl)
    );

    stap_ir u_ir (
        .ftap_tck (ftap_tck),
        .arst_n   (arst_n),
        .tdi      (tdi),
        .ctrl     (ctrl),
        .ir_so    (ir_so),
        .tdr_sel  (tdr_sel),
        .path     (path)
    );

    // --------------------------------------------------
    // Test data register bank
    // --------------------------------------------------
    for (genvar k = 0; k < NUM_TDR; k++) begin : g_tdr
        stap_tdr u_tdr (
            .ftap_tck (ftap_tck),
            .arst_n   (arst_n),
            .tdi      (tdi),
            .ctrl     (ctrl),
            .sel      (tdr_sel[k]),
            .data_in  (tdr_data_in[k]),
            .so       (tdr_so[k]),
            .data_out (tdr_data_out[k])
        );
    end

    // Scan output
    stap_tdo_path u_tdo_path (
        .ftap_tck (ftap_tck),
        .arst_n   (arst_n),
        .tdi      (tdi),
        .ctrl     (ctrl),
        .path     (path),
        .tdr_sel  (tdr_sel),
        .ir_so    (ir_so),
        .tdr_so   (tdr_so),
        .tdo      (tdo),
        .tdo_en   (tdo_en)
    );

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_stap -o tb_stap

out=$(./obj_dir/tb_stap 2>&1)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Simulation completed successfully"; then
    exit 0
else
    exit 1
fi

/* tb.f */
design/stap_pkg.sv
design/stap_tdr_pkg.sv
design/stap_fsm.sv
design/stap_ir.sv
design/stap_tdr.sv
design/stap_tdo_path.sv
design/stap_top.sv
verif/stap_assertions.sv
verif/tb_stap.sv

/* verif/stap_assertions.sv */
/*
 * sTAP protocol assertions
 * Watches the scan enable, the controller strobes and the
 * timing of the TDR parallel outputs
 */

`timescale 1ns/1ps

module stap_assertions (
    input logic                                                ftap_tck,
    input logic                                                arst_n,
    input logic                                                tdo_en,
    input stap_pkg::tap_ctrl_t                                 ctrl,
    input stap_tdr_pkg::tdr_data_t [stap_tdr_pkg::NUM_TDR-1:0] tdr_data_out
);

    // Enable set on the falling edge from the state still current here
    a_tdo_en_shift: assert property (@(posedge ftap_tck) disable iff (!arst_n)
        tdo_en |-> (ctrl.shift_dr || ctrl.shift_ir))
        else $error("tdo_en high outside a shift state");

    // Decoded strobes
    a_ctrl_onehot: assert property (@(posedge ftap_tck) disable iff (!arst_n)
        $onehot0(ctrl))
        else $error("more than one TAP control strobe active");

    // Update register moves only off Update-DR or the tlr clear
    a_tdr_update: assert property (@(posedge ftap_tck) disable iff (!arst_n)
        $changed(tdr_data_out) |-> ($past(ctrl.update_dr) || $past(ctrl.tlr)))
        else $error("tdr_data_out changed without a preceding Update-DR");

endmodule

bind stap_top stap_assertions u_assertions (
    .ftap_tck     (ftap_tck),
    .arst_n       (arst_n),
    .tdo_en       (tdo_en),
    .ctrl         (ctrl),
    .tdr_data_out (tdr_data_out)
);

/* verif/tb_stap.sv */
/*
 * sTAP testbench
 * Walks the TAP through IDCODE, IR, bypass and TDR scans and checks
 * scan-out, tdo_en and the TDR parallel outputs against a reference
 */

`timescale 1ns/1ps

module tb_stap;

    import stap_pkg::*;
    import stap_tdr_pkg::*;

    localparam int TCK_HALF = 20;
    // TCK cost of one scan beyond its shifted bits
    localparam int DR_OVH = 8;
    localparam int IR_OVH = 9;
    localparam int TEST_CYCLES = 12 + (32 + DR_OVH) + (4 + IR_OVH)
        + 2 * ((4 + IR_OVH) + (16 + DR_OVH))
        + NUM_TDR * ((4 + IR_OVH) + 2 * (8 + DR_OVH))
        + 6 + (32 + DR_OVH) + 4;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    typedef logic [63:0] word_t;

    logic                    ftap_tck;
    logic                    arst_n;
    logic                    tms;
    logic                    tdi;
    logic                    tdo;
    logic                    tdo_en;
    tdr_data_t [NUM_TDR-1:0] tdr_data_in;
    tdr_data_t [NUM_TDR-1:0] tdr_data_out;

    // Reference state
    logic [31:0]             lfsr_state;
    ir_t                     cur_ir;
    tdr_data_t [NUM_TDR-1:0] model_out;
    int                      cycles;
    int                      test_count;
    int                      error_count;
    string                   name_q[$];
    word_t                   exp_q[$];
    word_t                   act_q[$];

    stap_top u_dut (
        .ftap_tck     (ftap_tck),
        .arst_n       (arst_n),
        .tms          (tms),
        .tdi          (tdi),
        .tdo          (tdo),
        .tdo_en       (tdo_en),
        .tdr_data_in  (tdr_data_in),
        .tdr_data_out (tdr_data_out)
    );

    initial begin
        ftap_tck = 1'b0;
        forever begin
            #(TCK_HALF);
            ftap_tck = ~ftap_tck;
        end
    end

    // --------------------------------------------------
    // Random source and reference model
    // --------------------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t random_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v[i] = lfsr_state[0];
        end
        return v;
    endfunction

    // Captured value leaves first, then the bits shifted in behind it
    function automatic word_t expected_scan(input logic ir_scan, input ir_t opcode,
                                            input int nbits, input word_t shift_in,
                                            input tdr_data_t [NUM_TDR-1:0] cap);
        word_t reg_val;
        word_t result;
        int    width;
        int    idx;
        // Bypass and undecoded opcodes
        reg_val = '0;
        width   = 1;
        idx     = int'(opcode) - int'(OPC_TDR_BASE);
        if (ir_scan) begin
            reg_val = word_t'(IR_CAPTURE);
            width   = IR_WIDTH;
        end else if (opcode == OPC_IDCODE) begin
            reg_val = word_t'(IDCODE_VALUE);
            width   = IDCODE_WIDTH;
        end else if (idx >= 0 && idx < NUM_TDR) begin
            reg_val = word_t'(cap[idx]);
            width   = TDR_WIDTH;
        end
        result = '0;
        for (int i = 0; i < nbits; i++) begin
            if (i < width) begin
                result[i] = reg_val[i];
            end else begin
                result[i] = shift_in[i - width];
            end
        end
        return result;
    endfunction

    task automatic push_check(input string name, input word_t exp, input word_t act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    // --------------------------------------------------
    // JTAG stimulus
    // --------------------------------------------------
    task automatic drive_jtag(input logic tms_v, input logic tdi_v);
        @(posedge ftap_tck);
        tms <= tms_v;
        tdi <= tdi_v;
    endtask

    // Quarter period past the falling edge, where TDO and tdo_en are stable
    task automatic wait_tdo_stable();
        @(negedge ftap_tck);
        #(TCK_HALF / 2);
    endtask

    // Five TMS-high clocks, then park toward Run-Test/Idle
    task automatic go_to_reset();
        repeat (5) drive_jtag(1'b1, 1'b0);
        drive_jtag(1'b0, 1'b0);
        cur_ir    = OPC_IDCODE;
        model_out = '0;
    endtask

    task automatic new_capture_data();
        @(posedge ftap_tck);
        for (int k = 0; k < NUM_TDR; k++) begin
            tdr_data_in[k] <= tdr_data_t'(random_bits(TDR_WIDTH));
        end
    endtask

    // Full scan from Run-Test/Idle back to Run-Test/Idle
    task automatic run_scan(input string name, input logic ir_scan, input int nbits,
                            input word_t data_in);
        word_t      bits;
        logic [2:0] en_seen;
        logic       en_all;
        int         idx;
        bits   = '0;
        en_all = 1'b1;
        drive_jtag(1'b1, 1'b0);
        if (ir_scan) begin
            drive_jtag(1'b1, 1'b0);
        end
        drive_jtag(1'b0, 1'b0);
        drive_jtag(1'b0, 1'b0);
        // Capture state, enable still low
        wait_tdo_stable();
        en_seen[2] = tdo_en;
        for (int i = 0; i < nbits; i++) begin
            drive_jtag(i == nbits - 1, data_in[i]);
            wait_tdo_stable();
            bits[i] = tdo;
            en_all  = en_all & tdo_en;
        end
        en_seen[1] = en_all;
        // Exit1, Update, then idle past the update edge
        drive_jtag(1'b1, 1'b0);
        drive_jtag(1'b0, 1'b0);
        drive_jtag(1'b0, 1'b0);
        wait_tdo_stable();
        en_seen[0] = tdo_en;
        push_check({name, " scan out"},
                   expected_scan(ir_scan, cur_ir, nbits, data_in, tdr_data_in), bits);
        push_check({name, " tdo_en"}, word_t'(3'b010), word_t'(en_seen));
        if (ir_scan) begin
            cur_ir = ir_t'(data_in[IR_WIDTH-1:0]);
        end else begin
            idx = int'(cur_ir) - int'(OPC_TDR_BASE);
            // Last TDR_WIDTH bits shifted in land in the update stage
            if (idx >= 0 && idx < NUM_TDR) begin
                for (int j = 0; j < TDR_WIDTH; j++) begin
                    model_out[idx][j] = data_in[nbits - TDR_WIDTH + j];
                end
            end
        end
        push_check({name, " data_out"}, word_t'(model_out), word_t'(tdr_data_out));
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        lfsr_state  = 32'ha7ec;
        arst_n      = 1'b0;
        tms         = 1'b0;
        tdi         = 1'b0;
        tdr_data_in = '0;
        cur_ir      = OPC_IDCODE;
        model_out   = '0;
        repeat (5) @(posedge ftap_tck);
        arst_n <= 1'b1;
        wait_tdo_stable();
        push_check("reset outputs", '0, word_t'({tdo_en, tdo, tdr_data_out}));

        run_scan("idcode after reset", 1'b0, 32, random_bits(32));
        run_scan("ir load bypass", 1'b1, 4, word_t'(OPC_BYPASS));
        run_scan("bypass", 1'b0, 16, random_bits(16));
        // 4'h5 lies outside every decoded opcode
        run_scan("ir load undecoded", 1'b1, 4, 64'h5);
        run_scan("undecoded bypass", 1'b0, 16, random_bits(16));

        for (int k = 0; k < NUM_TDR; k++) begin
            run_scan($sformatf("ir load tdr%0d", k), 1'b1, 4,
                     word_t'(int'(OPC_TDR_BASE) + k));
            new_capture_data();
            run_scan($sformatf("tdr%0d write", k), 1'b0, TDR_WIDTH, random_bits(TDR_WIDTH));
            new_capture_data();
            run_scan($sformatf("tdr%0d readback", k), 1'b0, TDR_WIDTH,
                     random_bits(TDR_WIDTH));
        end

        go_to_reset();
        wait_tdo_stable();
        push_check("tlr clears tdr_data_out", '0, word_t'(tdr_data_out));
        run_scan("idcode after tlr", 1'b0, 32, random_bits(32));

        // Let the comparator drain
        repeat (2) @(posedge ftap_tck);
        $display("Checks run: %0d, failed: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Comparator
    initial begin
        test_count  = 0;
        error_count = 0;
        forever begin
            @(posedge ftap_tck);
            while (name_q.size() > 0) begin
                test_count++;
                assert (act_q[0] == exp_q[0]) $display("ok       %s", name_q[0]);
                else begin
                    $display("** Error %s: expected %h, actual %h",
                             name_q[0], exp_q[0], act_q[0]);
                    error_count++;
                end
                void'(name_q.pop_front());
                void'(exp_q.pop_front());
                void'(act_q.pop_front());
            end
        end
    end

    // Watchdog
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge ftap_tck);
            cycles++;
        end
        $display("Timeout: scan sequence did not finish within %0d TCK cycles",
                 TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule
